//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  // bit 3 marks a load, bit 2 a signed load, and bits 1:0 give the size (0 byte, 1 half, 2 word).
  typedef enum logic [3:0] {
    op_sb  = 4'b0000,
    op_sh  = 4'b0001,
    op_sw  = 4'b0010,
    op_lbu = 4'b1000,
    op_lhu = 4'b1001,
    op_lb  = 4'b1100,
    op_lh  = 4'b1101,
    op_lw  = 4'b1110
  } lsu_op_t;

  typedef enum logic [3:0] {
    st_idle,
    st_load_req,
    st_load_resp,
    st_store_req,
    st_store_addr,
    st_store_data,
    st_store_resp,
    st_hold
  } lsu_state_t;

  function automatic logic op_is_load(lsu_op_t op);
    return op[3];
  endfunction

  function automatic logic op_is_signed(lsu_op_t op);
    return op[2];
  endfunction

  function automatic logic [1:0] op_size(lsu_op_t op);
    return op[1:0];
  endfunction

endpackage

`default_nettype wire

//--- rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  // bus geometry shared by the master and the memory.
  localparam int axi_addr_width = 32;
  localparam int axi_data_width = 32;
  localparam int axi_strb_width = axi_data_width / 8;

  // transfer size field, log2 of the bytes in the beat.
  typedef logic [2:0] axi_size_t;

  // incrementing burst.
  // single-beat transfers keep the length field at zero, so the type is of no consequence.
  localparam logic [1:0] axi_burst_incr = 2'b01;

endpackage

`default_nettype wire

//--- rtl/lsu_decode.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_decode import lsu_pkg::*, axi_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      accept,
  input  logic [3:0]                ls,
  input  logic [axi_addr_width-1:0] addr,
  input  logic [axi_data_width-1:0] wdata,
  output lsu_op_t                   op,
  output axi_size_t                 size,
  output logic [1:0]                byte_offset,
  output logic [axi_addr_width-1:0] req_addr,
  output logic [axi_data_width-1:0] lane_wdata,
  output logic [axi_strb_width-1:0] wstrb
);

  lsu_op_t                   op_q;
  logic [axi_data_width-1:0] wdata_q;
  logic [axi_strb_width-1:0] base_strb;

  always_ff @(posedge clock) begin
    if (reset) begin
      op_q <= op_lw;
    end else if (accept) begin
      op_q <= lsu_op_t'(ls);
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      req_addr <= addr;
      wdata_q  <= wdata;
    end
  end

  // the incoming code is forwarded so execute picks its path on the accepting edge.
  assign op = accept ? lsu_op_t'(ls) : op_q;

  assign size        = {1'b0, op_size(op_q)};
  assign byte_offset = req_addr[1:0];

  always_comb begin
    case (op_size(op_q))
      2'd0:    base_strb = 4'b0001;
      2'd1:    base_strb = 4'b0011;
      default: base_strb = 4'b1111;
    endcase
  end

  // move the low bytes of the store data up to their lanes.
  assign lane_wdata = wdata_q << {byte_offset, 3'b000};
  assign wstrb      = base_strb << byte_offset;

endmodule

`default_nettype wire

//--- rtl/lsu_execute.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_execute import lsu_pkg::*; (
  input  logic    clock,
  input  logic    reset,

  input  logic    in_valid,
  output logic    in_ready,
  output logic    accept,
  input  lsu_op_t op,

  input  logic    out_ready,
  output logic    out_valid,
  output logic    capture,

  output logic    arvalid,
  input  logic    arready,
  input  logic    rvalid,
  output logic    rready,

  output logic    awvalid,
  input  logic    awready,
  output logic    wvalid,
  input  logic    wready,
  input  logic    bvalid,
  output logic    bready
);

  lsu_state_t state;
  lsu_state_t state_next;

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= st_idle;
    end else begin
      state <= state_next;
    end
  end

  // a new request may enter while the previous result leaves.
  assign in_ready = (state == st_idle) || ((state == st_hold) && out_ready);
  assign accept   = in_valid && in_ready;

  always_comb begin
    state_next = state;
    case (state)
      st_idle, st_hold: begin
        if (accept) begin
          state_next = op_is_load(op) ? st_load_req : st_store_req;
        end else if (state == st_hold && out_ready) begin
          state_next = st_idle;
        end
      end

      st_load_req: begin
        if (arready) begin
          state_next = st_load_resp;
        end
      end

      st_load_resp: begin
        if (rvalid) begin
          state_next = st_hold;
        end
      end

      st_store_req: begin
        if (awready && wready) begin
          state_next = st_store_resp;
        end else if (awready) begin
          state_next = st_store_data;
        end else if (wready) begin
          state_next = st_store_addr;
        end
      end

      // data went first, address still pending.
      st_store_addr: begin
        if (awready) begin
          state_next = st_store_resp;
        end
      end

      // address went first, data still pending.
      st_store_data: begin
        if (wready) begin
          state_next = st_store_resp;
        end
      end

      st_store_resp: begin
        if (bvalid) begin
          state_next = st_hold;
        end
      end

      default: state_next = st_idle;
    endcase
  end

  assign arvalid = (state == st_load_req);
  assign rready  = (state == st_load_resp);
  assign capture = rvalid && rready;

  assign awvalid = (state == st_store_req) || (state == st_store_addr);
  assign wvalid  = (state == st_store_req) || (state == st_store_data);
  assign bready  = (state == st_store_resp);

  assign out_valid = (state == st_hold);

endmodule

`default_nettype wire

//--- rtl/lsu_result.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_result import lsu_pkg::*, axi_pkg::*; (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      capture,
  input  logic [axi_data_width-1:0] rdata,
  input  lsu_op_t                   op,
  input  logic [1:0]                byte_offset,
  output logic [axi_data_width-1:0] out_rdata
);

  logic [axi_data_width-1:0] shifted;
  logic [axi_data_width-1:0] extended;
  logic                      fill_bit;

  // bring the addressed lane down to bit 0.
  assign shifted = rdata >> {byte_offset, 3'b000};

  always_comb begin
    fill_bit = 1'b0;
    case (op_size(op))
      2'd0: begin
        fill_bit = shifted[7] & op_is_signed(op);
        extended = {{(axi_data_width - 8){fill_bit}}, shifted[7:0]};
      end
      2'd1: begin
        fill_bit = shifted[15] & op_is_signed(op);
        extended = {{(axi_data_width - 16){fill_bit}}, shifted[15:0]};
      end
      default: extended = shifted;
    endcase
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      out_rdata <= '0;
    end else if (capture) begin
      out_rdata <= extended;
    end else if (!op_is_load(op)) begin
      // a store reports zero.
      out_rdata <= '0;
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_sram.sv
`timescale 1ns/100ps
`default_nettype none

module axi_sram import axi_pkg::*; #(
  parameter int mem_words  = 256,
  parameter int resp_delay = 2
) (
  input  logic                      clock,
  input  logic                      reset,

  input  logic                      arvalid,
  input  logic [axi_addr_width-1:0] araddr,
  input  axi_size_t                 arsize,
  output logic                      arready,
  output logic                      rvalid,
  output logic [axi_data_width-1:0] rdata,
  input  logic                      rready,

  input  logic                      awvalid,
  input  logic [axi_addr_width-1:0] awaddr,
  input  axi_size_t                 awsize,
  output logic                      awready,
  input  logic                      wvalid,
  input  logic [axi_data_width-1:0] wdata,
  input  logic [axi_strb_width-1:0] wstrb,
  output logic                      wready,
  output logic                      bvalid,
  input  logic                      bready
);

  localparam int index_width = $clog2(mem_words);
  localparam int count_width = $clog2(resp_delay + 2);

  typedef enum logic [1:0] {
    sram_idle,
    sram_read,
    sram_write
  } sram_state_t;

  sram_state_t               state;
  logic [count_width-1:0]    count;
  logic [axi_data_width-1:0] mem [mem_words];

  logic                      aw_seen;
  logic                      w_seen;
  logic [index_width-1:0]    aw_index_q;
  logic [axi_strb_width-1:0] aw_lanes_q;
  logic [axi_data_width-1:0] wdata_q;
  logic [axi_strb_width-1:0] wstrb_q;

  logic                      ar_fire;
  logic                      aw_fire;
  logic                      w_fire;
  logic                      wr_go;
  logic [index_width-1:0]    wr_index;
  logic [axi_strb_width-1:0] wr_strb;
  logic [axi_data_width-1:0] wr_data;

  // byte lanes a narrow transfer covers.
  function automatic logic [axi_strb_width-1:0] lanes(axi_size_t sz, logic [1:0] offset);
    logic [axi_strb_width-1:0] base;
    case (sz)
      3'd0:    base = 4'b0001;
      3'd1:    base = 4'b0011;
      default: base = 4'b1111;
    endcase
    return base << offset;
  endfunction

  function automatic logic [axi_data_width-1:0] byte_mask(logic [axi_strb_width-1:0] strb);
    logic [axi_data_width-1:0] mask;
    for (int i = 0; i < axi_strb_width; i++) begin
      mask[8*i +: 8] = {8{strb[i]}};
    end
    return mask;
  endfunction

  assign arready = (state == sram_idle);
  assign awready = (state == sram_idle) && !aw_seen;
  assign wready  = (state == sram_idle) && !w_seen;

  assign ar_fire = arvalid && arready;
  assign aw_fire = awvalid && awready;
  assign w_fire  = wvalid && wready;

  // a write commits once address and data have both arrived, in either order.
  assign wr_go = (state == sram_idle) && !ar_fire && (aw_seen || aw_fire) && (w_seen || w_fire);

  assign wr_index = aw_seen ? aw_index_q : awaddr[index_width+1:2];
  assign wr_data  = w_seen ? wdata_q : wdata;
  assign wr_strb  = (w_seen ? wstrb_q : wstrb)
                  & (aw_seen ? aw_lanes_q : lanes(awsize, awaddr[1:0]));

  assign rvalid = (state == sram_read) && (count == '0);
  assign bvalid = (state == sram_write) && (count == '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      state   <= sram_idle;
      count   <= '0;
      aw_seen <= 1'b0;
      w_seen  <= 1'b0;
    end else begin
      case (state)
        sram_idle: begin
          if (ar_fire) begin
            state <= sram_read;
            count <= count_width'(resp_delay);
          end else if (wr_go) begin
            state   <= sram_write;
            count   <= count_width'(resp_delay);
            aw_seen <= 1'b0;
            w_seen  <= 1'b0;
          end else begin
            if (aw_fire) aw_seen <= 1'b1;
            if (w_fire) w_seen <= 1'b1;
          end
        end
        sram_read: begin
          if (count != '0) begin
            count <= count - 1'b1;
          end else if (rready) begin
            state <= sram_idle;
          end
        end
        sram_write: begin
          if (count != '0) begin
            count <= count - 1'b1;
          end else if (bready) begin
            state <= sram_idle;
          end
        end
        default: state <= sram_idle;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (ar_fire) begin
      rdata <= mem[araddr[index_width+1:2]] & byte_mask(lanes(arsize, araddr[1:0]));
    end
    if (aw_fire) begin
      aw_index_q <= awaddr[index_width+1:2];
      aw_lanes_q <= lanes(awsize, awaddr[1:0]);
    end
    if (w_fire) begin
      wdata_q <= wdata;
      wstrb_q <= wstrb;
    end
    if (wr_go) begin
      for (int i = 0; i < axi_strb_width; i++) begin
        if (wr_strb[i]) mem[wr_index][8*i +: 8] <= wr_data[8*i +: 8];
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_top import lsu_pkg::*, axi_pkg::*; #(
  parameter int mem_words  = 256,
  parameter int resp_delay = 2
) (
  input  logic                      clock,
  input  logic                      reset,
  input  logic                      in_valid,
  output logic                      in_ready,
  input  logic [3:0]                ls,
  input  logic [axi_addr_width-1:0] addr,
  input  logic [axi_data_width-1:0] wdata,
  output logic                      out_valid,
  input  logic                      out_ready,
  output logic [axi_data_width-1:0] out_rdata
);

  logic                      accept;
  logic                      capture;
  lsu_op_t                   op;
  axi_size_t                 size;
  logic [1:0]                byte_offset;
  logic [axi_addr_width-1:0] req_addr;
  logic [axi_data_width-1:0] lane_wdata;
  logic [axi_strb_width-1:0] wstrb;

  logic                      arvalid;
  logic                      arready;
  logic                      rvalid;
  logic                      rready;
  logic [axi_data_width-1:0] rdata;
  logic                      awvalid;
  logic                      awready;
  logic                      wvalid;
  logic                      wready;
  logic                      bvalid;
  logic                      bready;

  lsu_decode u_decode (
    .clock      (clock),
    .reset      (reset),
    .accept     (accept),
    .ls         (ls),
    .addr       (addr),
    .wdata      (wdata),
    .op         (op),
    .size       (size),
    .byte_offset(byte_offset),
    .req_addr   (req_addr),
    .lane_wdata (lane_wdata),
    .wstrb      (wstrb)
  );

  lsu_execute u_execute (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .accept   (accept),
    .op       (op),
    .out_ready(out_ready),
    .out_valid(out_valid),
    .capture  (capture),
    .arvalid  (arvalid),
    .arready  (arready),
    .rvalid   (rvalid),
    .rready   (rready),
    .awvalid  (awvalid),
    .awready  (awready),
    .wvalid   (wvalid),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready)
  );

  lsu_result u_result (
    .clock      (clock),
    .reset      (reset),
    .capture    (capture),
    .rdata      (rdata),
    .op         (op),
    .byte_offset(byte_offset),
    .out_rdata  (out_rdata)
  );

  // one request at a time, so read and write share the captured address and size.
  axi_sram #(
    .mem_words (mem_words),
    .resp_delay(resp_delay)
  ) u_sram (
    .clock  (clock),
    .reset  (reset),
    .arvalid(arvalid),
    .araddr (req_addr),
    .arsize (size),
    .arready(arready),
    .rvalid (rvalid),
    .rdata  (rdata),
    .rready (rready),
    .awvalid(awvalid),
    .awaddr (req_addr),
    .awsize (size),
    .awready(awready),
    .wvalid (wvalid),
    .wdata  (lane_wdata),
    .wstrb  (wstrb),
    .wready (wready),
    .bvalid (bvalid),
    .bready (bready)
  );

endmodule

`default_nettype wire

//--- verification/lsu_checker.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_checker import axi_pkg::*; (
  input logic                      clock,
  input logic                      reset,
  input logic                      in_ready,
  input logic                      out_valid,
  input logic                      out_ready,
  input logic [axi_data_width-1:0] out_rdata,
  input logic                      arvalid,
  input logic                      arready,
  input logic [axi_addr_width-1:0] araddr,
  input logic                      rvalid,
  input logic                      rready,
  input logic [axi_data_width-1:0] rdata,
  input logic                      awvalid,
  input logic                      awready,
  input logic [axi_addr_width-1:0] awaddr,
  input logic                      wvalid,
  input logic                      wready,
  input logic [axi_data_width-1:0] wdata,
  input logic [axi_strb_width-1:0] wstrb,
  input logic                      bvalid,
  input logic                      bready
);

  int failures = 0;

  // every valid holds with its payload until it meets ready.
  ar_hold: assert property (@(posedge clock) disable iff (reset)
    arvalid && !arready |=> arvalid && $stable(araddr))
  else begin
    failures++;
    $error("arvalid dropped or araddr changed before arready");
  end

  r_hold: assert property (@(posedge clock) disable iff (reset)
    rvalid && !rready |=> rvalid && $stable(rdata))
  else begin
    failures++;
    $error("rvalid dropped or rdata changed before rready");
  end

  aw_hold: assert property (@(posedge clock) disable iff (reset)
    awvalid && !awready |=> awvalid && $stable(awaddr))
  else begin
    failures++;
    $error("awvalid dropped or awaddr changed before awready");
  end

  w_hold: assert property (@(posedge clock) disable iff (reset)
    wvalid && !wready |=> wvalid && $stable(wdata) && $stable(wstrb))
  else begin
    failures++;
    $error("wvalid dropped or write data changed before wready");
  end

  b_hold: assert property (@(posedge clock) disable iff (reset)
    bvalid && !bready |=> bvalid)
  else begin
    failures++;
    $error("bvalid dropped before bready");
  end

  // result side back-pressure.
  out_hold: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |=> out_valid && $stable(out_rdata))
  else begin
    failures++;
    $error("out_valid dropped or out_rdata changed before out_ready");
  end

  in_blocked: assert property (@(posedge clock) disable iff (reset)
    out_valid && !out_ready |-> !in_ready)
  else begin
    failures++;
    $error("in_ready high while the result is stalled");
  end

  one_request: assert property (@(posedge clock) disable iff (reset)
    !(arvalid && awvalid))
  else begin
    failures++;
    $error("arvalid and awvalid high together");
  end

  strb_nonzero: assert property (@(posedge clock) disable iff (reset)
    wvalid |-> wstrb != '0)
  else begin
    failures++;
    $error("wvalid high with an empty strobe");
  end

  after_reset: assert property (@(posedge clock)
    reset |=> !out_valid && !arvalid && !awvalid && !wvalid && !rvalid && !bvalid && in_ready)
  else begin
    failures++;
    $error("handshake signals not idle after reset");
  end

endmodule

`default_nettype wire

//--- verification/lsu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module lsu_tb import lsu_pkg::*; ();

  localparam int mem_words      = 256;
  localparam int resp_delay     = 2;
  localparam int timeout_cycles = 200;

  logic        clock;
  logic        reset;
  logic        in_valid;
  logic        in_ready;
  logic [3:0]  ls;
  logic [31:0] addr;
  logic [31:0] wdata;
  logic        out_valid;
  logic        out_ready;
  logic [31:0] out_rdata;

  logic [7:0]  model [mem_words * 4];
  logic [31:0] expected_q [$];
  logic [31:0] expected;
  lsu_op_t     ops [8] = '{op_lb, op_lh, op_lw, op_lbu, op_lhu, op_sb, op_sh, op_sw};
  string       test_name;
  int          errors;
  int          errors_at_start;
  int          tests;
  int          failed_tests;
  bit          timed_out;
  bit          stall_mode;
  bit          stall_now;

  lsu_top #(
    .mem_words (mem_words),
    .resp_delay(resp_delay)
  ) UUT (
    .clock    (clock),
    .reset    (reset),
    .in_valid (in_valid),
    .in_ready (in_ready),
    .ls       (ls),
    .addr     (addr),
    .wdata    (wdata),
    .out_valid(out_valid),
    .out_ready(out_ready),
    .out_rdata(out_rdata)
  );

  bind lsu_top lsu_checker u_checker (.*, .araddr(req_addr), .awaddr(req_addr), .wdata(lane_wdata));

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  // random stretches of output back-pressure.
  initial begin
    out_ready = 1'b1;
    forever begin
      @(posedge clock);
      stall_now = stall_mode;
      #1;
      out_ready = stall_now ? ($urandom_range(0, 2) == 0) : 1'b1;
    end
  end

  // each result transfer is compared with the oldest prediction.
  always @(negedge clock) begin
    if (!reset && out_valid && out_ready) begin
      if (expected_q.size() == 0) begin
        $display("result transfer with no request outstanding in %s", test_name);
        errors++;
      end else begin
        expected = expected_q.pop_front();
        assert (out_rdata === expected)
        else begin
          $display("error: %s expected %08h actual %08h", test_name, expected, out_rdata);
          errors++;
        end
      end
    end
  end

  // bit 3 load, bit 2 signed, bits 1:0 log2 of the byte count.
  function automatic logic [31:0] model_access(logic [3:0] code, logic [31:0] a, logic [31:0] d);
    int          nbytes;
    logic [31:0] value;
    nbytes = 1 << code[1:0];
    value  = '0;
    for (int i = 0; i < nbytes; i++) begin
      if (code[3]) begin
        value[8*i +: 8] = model[(a + i) % (mem_words * 4)];
      end else begin
        model[(a + i) % (mem_words * 4)] = d[8*i +: 8];
      end
    end
    if (code[3] && code[2] && nbytes < 4 && value[8*nbytes-1]) begin
      value = value | (32'hffff_ffff << (8 * nbytes));
    end
    return value;
  endfunction

  function automatic logic [31:0] random_addr(lsu_op_t op);
    logic [31:0] a;
    a = $urandom_range(0, mem_words - 1) * 4;
    if (op[1:0] == 2'd0) begin
      a = a + $urandom_range(0, 3);
    end else if (op[1:0] == 2'd1) begin
      a = a + 2 * $urandom_range(0, 1);
    end
    return a;
  endfunction

  task automatic send(lsu_op_t op, logic [31:0] a, logic [31:0] d);
    int waited;
    waited = 0;
    if (timed_out) return;
    ls       = op;
    addr     = a;
    wdata    = d;
    in_valid = 1'b1;
    @(negedge clock);
    while (!in_ready) begin
      if (waited == timeout_cycles) begin
        $display("timed out in %s waiting for in_ready", test_name);
        timed_out = 1'b1;
        return;
      end
      waited++;
      @(negedge clock);
    end
    @(posedge clock);
    expected_q.push_back(model_access(op, a, d));
    #1;
  endtask

  task automatic send_random();
    lsu_op_t op;
    op = ops[$urandom_range(0, 7)];
    send(op, random_addr(op), $urandom());
  endtask

  task automatic drain();
    int waited;
    waited   = 0;
    in_valid = 1'b0;
    while (expected_q.size() != 0 && !timed_out) begin
      if (waited == timeout_cycles) begin
        $display("timed out in %s waiting for out_valid", test_name);
        timed_out = 1'b1;
      end else begin
        waited++;
        @(posedge clock);
      end
    end
    @(posedge clock);
    #1;
  endtask

  task automatic start_test(string name);
    test_name       = name;
    errors_at_start = errors + UUT.u_checker.failures;
  endtask

  task automatic finish_test();
    int found;
    drain();
    found = errors + UUT.u_checker.failures - errors_at_start;
    tests++;
    if (found != 0 || timed_out) begin
      failed_tests++;
    end
    $display("%s: %s, %0d errors", test_name, (found == 0 && !timed_out) ? "ok" : "failed", found);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] d;
    void'($urandom(32'ha254a4b5));
    reset    = 1'b1;
    in_valid = 1'b0;
    ls       = 4'b0000;
    addr     = '0;
    wdata    = '0;
    repeat (3) @(posedge clock);
    #1;
    reset = 1'b0;

    start_test("memory_fill");
    for (int w = 0; w < mem_words; w++) begin
      send(op_sw, w * 4, $urandom());
    end
    finish_test();

    start_test("word_roundtrip");
    for (int k = 0; k < 16; k++) begin
      a = k * 64 + 4;
      send(op_sw, a, $urandom());
      send(op_lw, a, '0);
    end
    finish_test();

    start_test("narrow_stores");
    for (int k = 0; k < 8; k++) begin
      a = $urandom_range(0, mem_words - 1) * 4;
      for (int b = 0; b < 4; b++) begin
        send(op_sb, a + b, $urandom());
        send(op_lw, a, '0);
      end
      for (int h = 0; h < 4; h += 2) begin
        send(op_sh, a + h, $urandom());
        send(op_lw, a, '0);
      end
    end
    finish_test();

    // odd words carry set sign bits in every lane, even words clear ones.
    start_test("load_extend");
    for (int k = 0; k < 8; k++) begin
      a = $urandom_range(0, mem_words - 1) * 4;
      d = $urandom();
      d = k[0] ? (d | 32'h8080_8080) : (d & 32'h7f7f_7f7f);
      send(op_sw, a, d);
      for (int b = 0; b < 4; b++) begin
        send(op_lb, a + b, '0);
        send(op_lbu, a + b, '0);
      end
      for (int h = 0; h < 4; h += 2) begin
        send(op_lh, a + h, '0);
        send(op_lhu, a + h, '0);
      end
    end
    finish_test();

    start_test("backpressure");
    stall_mode = 1'b1;
    for (int k = 0; k < 40; k++) begin
      send_random();
    end
    finish_test();
    stall_mode = 1'b0;

    start_test("random_mix");
    for (int k = 0; k < 200; k++) begin
      send_random();
    end
    finish_test();

    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests, failed_tests, errors, UUT.u_checker.failures);
    if (failed_tests == 0 && errors == 0 && UUT.u_checker.failures == 0 && !timed_out) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
rtl/lsu_pkg.sv
rtl/axi_pkg.sv
rtl/lsu_decode.sv
rtl/lsu_execute.sv
rtl/lsu_result.sv
rtl/axi_sram.sv
rtl/lsu_top.sv
verification/lsu_checker.sv
verification/lsu_tb.sv

//--- Bender.yml
package:
  name: lsu

sources:
  - rtl/lsu_pkg.sv
  - rtl/axi_pkg.sv
  - rtl/lsu_decode.sv
  - rtl/lsu_execute.sv
  - rtl/lsu_result.sv
  - rtl/axi_sram.sv
  - rtl/lsu_top.sv
  - target: test
    files:
      - verification/lsu_checker.sv
      - verification/lsu_tb.sv
